/* vlog.f */
logic/execPkg.sv
logic/opDecoder.sv
logic/aluController.sv
logic/aluCore.sv
logic/hiLoUnit.sv
logic/resultStage.sv
logic/execTop.sv
verif/execTb.sv

/* verif/execTb.sv */
`timescale 1ns/1ps

module execTb import execPkg::*; ();

    logic        clk;
    logic        rstN;
    logic        instrValid;
    logic [31:0] instr;
    logic [31:0] rsValue;
    logic [31:0] rtValue;
    logic [31:0] result;
    logic        regWrite;
    logic        illegal;
    logic        resultValid;
    logic [31:0] hi;
    logic [31:0] lo;

    logic [31:0] seed = 32'h51ce8d61;
    int          cycles = 0;
    logic [31:0] modelHi = '0;                          // reference copy of HI/LO
    logic [31:0] modelLo = '0;

    // one burst of strobes and the pulses it produced
    logic [31:0] burstWord [4];
    logic [31:0] burstRs [4];
    logic [31:0] burstRt [4];
    logic [31:0] burstRes [4];
    logic        burstWr [4];
    logic        burstIll [4];
    int          burstCyc [4];

    execTop execTop_inst (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .rsValue     (rsValue),
        .rtValue     (rtValue),
        .result      (result),
        .regWrite    (regWrite),
        .illegal     (illegal),
        .resultValid (resultValid),
        .hi          (hi),
        .lo          (lo)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin                       // ~170 strobes at a few cycles each
            failRun("Timeout: the tests did not finish within 2000 cycles");
        end
    end

    task failRun(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            failRun($sformatf("Error in %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    function automatic logic [31:0] nextRand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic logic [31:0] rWord(logic [5:0] op, logic [4:0] sh, logic [5:0] fn);
        return {op, 5'd1, 5'd2, 5'd3, sh, fn};
    endfunction

    function automatic logic [31:0] iWord(logic [5:0] op, logic [15:0] imm);
        return {op, 5'd1, 5'd2, imm};
    endfunction

    function automatic logic [31:0] rTypeModel(logic [5:0] fn, logic [31:0] rs,
                                               logic [31:0] rt, logic [4:0] sh);
        logic [4:0] v;
        v = rs[4:0];
        case (fn)
            fnSub:   return rs - rt;
            fnAnd:   return rs & rt;
            fnOr:    return rs | rt;
            fnNor:   return ~(rs | rt);
            fnXor:   return rs ^ rt;
            fnSll:   return rt << sh;
            fnSrl:   return rt >> sh;
            fnSra:   return $signed(rt) >>> sh;
            fnSllv:  return rt << v;
            fnSrav:  return $signed(rt) >>> v;
            fnRotrv: return (rt >> v) | (rt << (6'd32 - v));
            fnSlt:   return {31'd0, $signed(rs) < $signed(rt)};
            fnSltu:  return {31'd0, rs < rt};
            default: return rs + rt;                    // add, addu and unknown funct
        endcase
    endfunction

    function automatic logic [31:0] immModel(logic [5:0] op, logic [31:0] rs, logic [15:0] imm);
        logic [31:0] sx;
        logic [31:0] zx;
        sx = {{16{imm[15]}}, imm};
        zx = {16'd0, imm};
        case (op)
            opAndi:  return rs & zx;
            opOri:   return rs | zx;
            opXori:  return rs ^ zx;
            opSlti:  return {31'd0, $signed(rs) < $signed(sx)};
            opSltiu: return {31'd0, rs < sx};       // unsigned compare
            default: return rs + sx;
        endcase
    endfunction

    // strobes burstWord[0..n-1] back to back and records each pulse in order
    task automatic runBurst(input int n);
        int sent;
        int got;
        int firstCyc;
        sent     = 0;
        got      = 0;
        firstCyc = 0;
        while (got < n) begin
            @(negedge clk);
            if (resultValid && sent > got) begin
                burstRes[got] = result;
                burstWr[got]  = regWrite;
                burstIll[got] = illegal;
                burstCyc[got] = cycles;
                checkValue($sformatf("latency of strobe %0d", got),
                           firstCyc + got + 1, cycles);
                got++;
            end
            if (sent < n) begin
                if (sent == 0) begin
                    firstCyc = cycles;                  // cycle of the first strobe
                end
                instrValid = 1'b1;
                instr      = burstWord[sent];
                rsValue    = burstRs[sent];
                rtValue    = burstRt[sent];
                sent++;
            end else begin
                instrValid = 1'b0;
            end
        end
        @(negedge clk);
        if (resultValid) begin
            failRun("resultValid stayed high after the last strobe");
        end
    endtask

    task automatic runOne(input logic [31:0] word, input logic [31:0] rs, input logic [31:0] rt);
        burstWord[0] = word;
        burstRs[0]   = rs;
        burstRt[0]   = rt;
        runBurst(1);
    endtask

    task automatic testRType();
        logic [5:0]  fns [15] = '{fnAdd, fnAddu, fnSub, fnAnd, fnOr, fnNor, fnXor, fnSll,
                                  fnSrl, fnSra, fnSllv, fnSrav, fnRotrv, fnSlt, fnSltu};
        logic [31:0] rs;
        logic [31:0] rt;
        logic [31:0] tmp;
        string       name;
        checkValue("reset resultValid", 1'b0, resultValid);
        checkValue("reset regWrite", 1'b0, regWrite);
        checkValue("reset illegal", 1'b0, illegal);
        checkValue("reset hi", 32'd0, hi);
        checkValue("reset lo", 32'd0, lo);
        checkValue("reset result", 32'd0, result);
        for (int i = 0; i < 15; i++) begin
            for (int r = 0; r < 4; r++) begin
                rs   = nextRand();
                rt   = nextRand();
                tmp  = nextRand();                      // shamt source
                name = $sformatf("rtype funct %b", fns[i]);
                runOne(rWord(opSpecial, tmp[4:0], fns[i]), rs, rt);
                checkValue(name, rTypeModel(fns[i], rs, rt, tmp[4:0]), burstRes[0]);
                checkValue({name, " regWrite"}, 1'b1, burstWr[0]);
            end
        end
    endtask

    task automatic testImmediates();
        logic [5:0]  ops [7] = '{opAddi, opAddiu, opSlti, opSltiu, opAndi, opOri, opXori};
        logic [15:0] imms [3] = '{16'hfff0, 16'h0123, 16'h8000};
        logic [31:0] rs;
        string       name;
        for (int i = 0; i < 7; i++) begin
            for (int j = 0; j < 3; j++) begin
                for (int k = 0; k < 2; k++) begin
                    rs   = (k == 0) ? nextRand() : 32'd5;
                    name = $sformatf("immediate op %b imm %h", ops[i], imms[j]);
                    runOne(iWord(ops[i], imms[j]), rs, nextRand());
                    checkValue(name, immModel(ops[i], rs, imms[j]), burstRes[0]);
                    checkValue({name, " regWrite"}, 1'b1, burstWr[0]);
                end
            end
        end
    endtask

    task automatic testHiLo();
        logic [31:0] words [6];
        logic [31:0] rs;
        logic [31:0] rt;
        logic [63:0] sProd;
        logic [63:0] uProd;
        words = '{rWord(opSpecial, 5'd0, fnMult), rWord(opSpecial, 5'd0, fnMultu),
                  rWord(opSpecial2, 5'd0, fnMadd), rWord(opSpecial2, 5'd0, fnMsub),
                  rWord(opSpecial, 5'd0, fnMthi), rWord(opSpecial, 5'd0, fnMtlo)};
        for (int round = 0; round < 2; round++) begin
            for (int i = 0; i < 6; i++) begin
                rs    = nextRand();
                rt    = nextRand();
                sProd = $signed({{32{rs[31]}}, rs}) * $signed({{32{rt[31]}}, rt});
                uProd = {32'd0, rs} * {32'd0, rt};
                burstWord[0] = words[i];
                burstRs[0]   = rs;
                burstRt[0]   = rt;
                burstWord[1] = rWord(opSpecial, 5'd0, fnMfhi);  // reads right behind
                burstWord[2] = rWord(opSpecial, 5'd0, fnMflo);
                for (int k = 1; k < 3; k++) begin
                    burstRs[k] = nextRand();
                    burstRt[k] = nextRand();
                end
                runBurst(3);
                case (i)
                    0: {modelHi, modelLo} = sProd;
                    1: {modelHi, modelLo} = uProd;
                    2: {modelHi, modelLo} = {modelHi, modelLo} + sProd;
                    3: {modelHi, modelLo} = {modelHi, modelLo} - sProd;
                    4: modelHi = rs;
                    default: modelLo = rs;
                endcase
                checkValue($sformatf("hilo op %0d regWrite", i), 1'b0, burstWr[0]);
                checkValue($sformatf("hilo op %0d hi", i), modelHi, hi);
                checkValue($sformatf("hilo op %0d lo", i), modelLo, lo);
                checkValue("mfhi after hilo op", modelHi, burstRes[1]);
                checkValue("mflo after hilo op", modelLo, burstRes[2]);
                checkValue("mfhi regWrite", 1'b1, burstWr[1]);
            end
        end
        rs    = nextRand();
        rt    = nextRand();
        sProd = $signed({{32{rs[31]}}, rs}) * $signed({{32{rt[31]}}, rt});
        runOne(rWord(opSpecial2, 5'd0, fnMul), rs, rt);
        checkValue("mul result", sProd[31:0], burstRes[0]);
        checkValue("mul regWrite", 1'b1, burstWr[0]);
        checkValue("mul keeps hi", modelHi, hi);
        checkValue("mul keeps lo", modelLo, lo);
    endtask

    task automatic testMoveExtend();
        logic [31:0] rs;
        logic [31:0] rt;
        logic [5:0]  fn;
        logic        expWr;
        for (int i = 0; i < 4; i++) begin
            rs    = nextRand();
            rt    = (i % 2 == 1) ? (nextRand() | 32'h1) : 32'h0;
            fn    = (i < 2) ? fnMovn : fnMovz;
            expWr = (fn == fnMovn) ? (rt != 0) : (rt == 0);
            runOne(rWord(opSpecial, 5'd0, fn), rs, rt);
            checkValue($sformatf("move funct %b regWrite", fn), expWr, burstWr[0]);
            if (expWr) begin
                checkValue($sformatf("move funct %b result", fn), rs, burstRes[0]);
            end
        end
        for (int k = 0; k < 3; k++) begin
            rt = (k == 0) ? 32'h1234_5680 : ((k == 1) ? 32'habcd_8001 : nextRand());
            runOne(rWord(opSpecial3, saSeb, fnBshfl), nextRand(), rt);
            checkValue("seb", {{24{rt[7]}}, rt[7:0]}, burstRes[0]);
            runOne(rWord(opSpecial3, saSeh, fnBshfl), nextRand(), rt);
            checkValue("seh", {{16{rt[15]}}, rt[15:0]}, burstRes[0]);
        end
    endtask

    task automatic testIllegalAndBurst();
        logic [5:0]  fns [4] = '{fnAdd, fnSub, fnXor, fnSllv};
        logic [31:0] rs;
        logic [31:0] rt;
        runOne(iWord(6'b111111, 16'h1234), nextRand(), nextRand());
        checkValue("unknown opcode illegal", 1'b1, burstIll[0]);
        checkValue("unknown opcode regWrite", 1'b0, burstWr[0]);
        rs = nextRand();
        rt = nextRand();
        runOne(rWord(opSpecial, 5'd0, 6'b111111), rs, rt);
        checkValue("unknown funct result", rs + rt, burstRes[0]);
        checkValue("unknown funct illegal", 1'b0, burstIll[0]);
        for (int k = 0; k < 4; k++) begin
            burstWord[k] = rWord(opSpecial, 5'd0, fns[k]);
            burstRs[k]   = nextRand();
            burstRt[k]   = nextRand();
        end
        runBurst(4);
        for (int k = 0; k < 4; k++) begin
            checkValue($sformatf("burst slot %0d", k),
                       rTypeModel(fns[k], burstRs[k], burstRt[k], 5'd0), burstRes[k]);
            checkValue($sformatf("burst slot %0d cycle", k), burstCyc[0] + k, burstCyc[k]);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        rsValue    = '0;
        rtValue    = '0;
        repeat (2) @(negedge clk);
        rstN = 1'b1;
        testRType();
        testImmediates();
        testHiLo();
        testMoveExtend();
        testIllegalAndBurst();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* logic/execTop.sv */
`timescale 1ns/1ps

module execTop import execPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  logic [dataWidth-1:0] instr,
    input  logic [dataWidth-1:0] rsValue,
    input  logic [dataWidth-1:0] rtValue,
    output logic [dataWidth-1:0] result,
    output logic                 regWrite,
    output logic                 illegal,
    output logic                 resultValid,
    output logic [dataWidth-1:0] hi,
    output logic [dataWidth-1:0] lo
);

    aluOpE                aluOp;
    aluCtrlE              aluCtrl;
    logic [dataWidth-1:0] opB;
    logic [dataWidth-1:0] aluResult;
    logic [dataWidth-1:0] mulLow;
    logic                 illegalOp;
    logic                 moveTaken;
    logic [5:0]           funct;
    logic [4:0]           shamt;
    logic [4:0]           sa;

    assign funct = instr[5:0];
    assign shamt = instr[10:6];
    assign sa    = instr[10:6];                         // bshfl reuses the shamt slot

    opDecoder opDecoder_inst (
        .instr     (instr),
        .rtValue   (rtValue),
        .aluOp     (aluOp),
        .opB       (opB),
        .illegalOp (illegalOp)
    );

    aluController aluController_inst (
        .aluOp   (aluOp),
        .funct   (funct),
        .aluCtrl (aluCtrl)
    );

    aluCore aluCore_inst (
        .aluCtrl   (aluCtrl),
        .rsValue   (rsValue),
        .opB       (opB),
        .hi        (hi),
        .lo        (lo),
        .shamt     (shamt),
        .sa        (sa),
        .aluResult (aluResult),
        .moveTaken (moveTaken)
    );

    hiLoUnit hiLoUnit_inst (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .aluCtrl    (aluCtrl),
        .rsValue    (rsValue),
        .rtValue    (rtValue),
        .hi         (hi),
        .lo         (lo),
        .mulLow     (mulLow)
    );

    resultStage resultStage_inst (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .illegalOp   (illegalOp),
        .aluCtrl     (aluCtrl),
        .aluResult   (aluResult),
        .mulLow      (mulLow),
        .moveTaken   (moveTaken),
        .result      (result),
        .regWrite    (regWrite),
        .illegal     (illegal),
        .resultValid (resultValid)
    );

endmodule

/* logic/resultStage.sv */
`timescale 1ns/1ps

module resultStage import execPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  logic                 illegalOp,
    input  aluCtrlE              aluCtrl,
    input  logic [dataWidth-1:0] aluResult,
    input  logic [dataWidth-1:0] mulLow,
    input  logic                 moveTaken,
    output logic [dataWidth-1:0] result,
    output logic                 regWrite,
    output logic                 illegal,
    output logic                 resultValid
);

    logic writesReg;

    always_comb begin
        case (aluCtrl)
            ctlMult, ctlMultu, ctlMadd,
            ctlMsub, ctlMthi, ctlMtlo: writesReg = 1'b0;   // only hi/lo change
            ctlMovn, ctlMovz:          writesReg = moveTaken;
            default:                   writesReg = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result      <= '0;
            regWrite    <= 1'b0;
            illegal     <= 1'b0;
            resultValid <= 1'b0;
        end else begin
            resultValid <= instrValid;
            regWrite    <= instrValid && writesReg && !illegalOp;
            illegal     <= instrValid && illegalOp;
            if (instrValid) begin
                result <= (aluCtrl == ctlMul) ? mulLow : aluResult;
            end
        end
    end

endmodule

/* logic/hiLoUnit.sv */
`timescale 1ns/1ps

module hiLoUnit import execPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 instrValid,
    input  aluCtrlE              aluCtrl,
    input  logic [dataWidth-1:0] rsValue,
    input  logic [dataWidth-1:0] rtValue,
    output logic [dataWidth-1:0] hi,
    output logic [dataWidth-1:0] lo,
    output logic [dataWidth-1:0] mulLow
);

    logic signed [2*dataWidth-1:0] sProd;
    logic        [2*dataWidth-1:0] uProd;

    assign sProd  = $signed(rsValue) * $signed(rtValue);
    assign uProd  = rsValue * rtValue;                  // operands widen to 64 bits
    assign mulLow = sProd[dataWidth-1:0];               // mul leaves hi/lo alone

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            hi <= '0;
            lo <= '0;
        end else if (instrValid) begin
            case (aluCtrl)
                ctlMult:  {hi, lo} <= sProd;
                ctlMultu: {hi, lo} <= uProd;
                ctlMadd:  {hi, lo} <= {hi, lo} + sProd; // accumulate
                ctlMsub:  {hi, lo} <= {hi, lo} - sProd;
                ctlMthi:  hi <= rsValue;
                ctlMtlo:  lo <= rsValue;
                default:  ;
            endcase
        end
    end

    hiLoHold: assert property (@(posedge clk) disable iff (!rstN)
        !$past(instrValid) |-> ($stable(hi) && $stable(lo)));

endmodule

/* logic/aluCore.sv */
`timescale 1ns/1ps

module aluCore import execPkg::*; (
    input  aluCtrlE              aluCtrl,
    input  logic [dataWidth-1:0] rsValue,
    input  logic [dataWidth-1:0] opB,
    input  logic [dataWidth-1:0] hi,
    input  logic [dataWidth-1:0] lo,
    input  logic [4:0]           shamt,
    input  logic [4:0]           sa,
    output logic [dataWidth-1:0] aluResult,
    output logic                 moveTaken
);

    logic [4:0]             varShift;
    logic [2*dataWidth-1:0] rotWide;
    logic [dataWidth-1:0]   extResult;

    assign varShift = rsValue[4:0];                     // variable shifts take rs low bits
    assign rotWide  = {opB, opB} >> varShift;

    // movn moves on nonzero rt, movz on zero rt
    assign moveTaken = ((aluCtrl == ctlMovn) && (opB != '0)) ||
                       ((aluCtrl == ctlMovz) && (opB == '0));

    always_comb begin
        case (sa)
            saSeb:   extResult = {{(dataWidth-8){opB[7]}}, opB[7:0]};
            saSeh:   extResult = {{(dataWidth-16){opB[15]}}, opB[15:0]};
            default: extResult = opB;
        endcase
    end

    always_comb begin
        case (aluCtrl)
            ctlAdd,
            ctlAddu:   aluResult = rsValue + opB;       // no overflow trap
            ctlSub:    aluResult = rsValue - opB;
            ctlAnd:    aluResult = rsValue & opB;
            ctlOr:     aluResult = rsValue | opB;
            ctlNor:    aluResult = ~(rsValue | opB);
            ctlXor:    aluResult = rsValue ^ opB;
            ctlSll:    aluResult = opB << shamt;
            ctlSrl:    aluResult = opB >> shamt;
            ctlSllv:   aluResult = opB << varShift;
            ctlSra:    aluResult = $signed(opB) >>> shamt;
            ctlSrav:   aluResult = $signed(opB) >>> varShift;
            ctlRotrv:  aluResult = rotWide[dataWidth-1:0];
            ctlSlt: begin
                aluResult = {{(dataWidth-1){1'b0}}, ($signed(rsValue) < $signed(opB))};
            end
            ctlSltu: begin
                aluResult = {{(dataWidth-1){1'b0}}, (rsValue < opB)};
            end
            ctlMovn,
            ctlMovz:   aluResult = rsValue;             // write gated by moveTaken
            ctlSebSeh: aluResult = extResult;
            ctlMfhi:   aluResult = hi;
            ctlMflo:   aluResult = lo;
            default:   aluResult = '0;                  // hi/lo ops, mul comes from hiLoUnit
        endcase
    end

endmodule

/* logic/aluController.sv */
`timescale 1ns/1ps

module aluController import execPkg::*; (
    input  aluOpE      aluOp,
    input  logic [5:0] funct,
    output aluCtrlE    aluCtrl
);

    always_comb begin
        aluCtrl = ctlAdd;
        if (aluOp == opDc) begin
            case (funct)                                // funct picks the r-type op
                fnAdd:   aluCtrl = ctlAdd;
                fnAddu:  aluCtrl = ctlAddu;
                fnSub:   aluCtrl = ctlSub;
                fnMult:  aluCtrl = ctlMult;
                fnMultu: aluCtrl = ctlMultu;
                fnAnd:   aluCtrl = ctlAnd;
                fnOr:    aluCtrl = ctlOr;
                fnNor:   aluCtrl = ctlNor;
                fnXor:   aluCtrl = ctlXor;
                fnSll:   aluCtrl = ctlSll;
                fnSrl:   aluCtrl = ctlSrl;
                fnSllv:  aluCtrl = ctlSllv;
                fnSlt:   aluCtrl = ctlSlt;
                fnMovn:  aluCtrl = ctlMovn;
                fnMovz:  aluCtrl = ctlMovz;
                fnRotrv: aluCtrl = ctlRotrv;
                fnSra:   aluCtrl = ctlSra;
                fnSrav:  aluCtrl = ctlSrav;
                fnSltu:  aluCtrl = ctlSltu;
                fnMfhi:  aluCtrl = ctlMfhi;
                fnMflo:  aluCtrl = ctlMflo;
                fnMthi:  aluCtrl = ctlMthi;
                fnMtlo:  aluCtrl = ctlMtlo;
                default: aluCtrl = ctlAdd;              // unknown funct acts as add
            endcase
        end else begin
            case (aluOp)
                addI:   aluCtrl = ctlAdd;
                subI:   aluCtrl = ctlSub;
                orI:    aluCtrl = ctlOr;
                andI:   aluCtrl = ctlAnd;
                xorI:   aluCtrl = ctlXor;
                norI:   aluCtrl = ctlNor;
                adduI:  aluCtrl = ctlAddu;
                subuI:  aluCtrl = ctlSub;
                multuI: aluCtrl = ctlMultu;
                sltI:   aluCtrl = ctlSlt;
                sltIu:  aluCtrl = ctlSltu;              // unsigned compare for sltiu
                mulOp: begin
                    if (funct == fnMul) begin
                        aluCtrl = ctlMul;
                    end else if (funct == fnMadd) begin
                        aluCtrl = ctlMadd;
                    end else if (funct == fnMsub) begin
                        aluCtrl = ctlMsub;
                    end else begin
                        aluCtrl = ctlAdd;
                    end
                end
                sebSehOp: begin
                    // only bshfl lives in special3 here
                    aluCtrl = (funct == fnBshfl) ? ctlSebSeh : ctlAdd;
                end
                default: aluCtrl = ctlAdd;
            endcase
        end
    end

endmodule

/* logic/opDecoder.sv */
`timescale 1ns/1ps

module opDecoder import execPkg::*; (
    input  logic [dataWidth-1:0] instr,
    input  logic [dataWidth-1:0] rtValue,
    output aluOpE                aluOp,
    output logic [dataWidth-1:0] opB,
    output logic                 illegalOp
);

    logic [5:0]           opcode;
    logic [15:0]          imm;
    logic [dataWidth-1:0] immSext;
    logic [dataWidth-1:0] immZext;

    assign opcode  = instr[31:26];
    assign imm     = instr[15:0];
    assign immSext = {{(dataWidth-16){imm[15]}}, imm};
    assign immZext = {{(dataWidth-16){1'b0}}, imm};     // logical immediates

    always_comb begin
        aluOp     = opDc;
        opB       = rtValue;                            // register forms use rt
        illegalOp = 1'b0;
        case (opcode)
            opSpecial:  aluOp = opDc;
            opSpecial2: aluOp = mulOp;
            opSpecial3: aluOp = sebSehOp;
            opAddi: begin
                aluOp = addI;
                opB   = immSext;
            end
            opAddiu: begin
                aluOp = adduI;
                opB   = immSext;
            end
            opSlti: begin
                aluOp = sltI;
                opB   = immSext;
            end
            opSltiu: begin
                aluOp = sltIu;
                opB   = immSext;                        // extended signed, compared unsigned
            end
            opAndi: begin
                aluOp = andI;
                opB   = immZext;
            end
            opOri: begin
                aluOp = orI;
                opB   = immZext;
            end
            opXori: begin
                aluOp = xorI;
                opB   = immZext;
            end
            default: begin
                // plain add class so funct can never reach HI/LO
                aluOp     = addI;
                illegalOp = 1'b1;
            end
        endcase
    end

endmodule

/* logic/execPkg.sv */
package execPkg;

    localparam int dataWidth = 32;                  // operand and result width

    // operation class coming out of the opcode decoder
    typedef enum logic [3:0] {
        opDc     = 4'd0,                             // r-type, funct decides
        addI,
        subI,
        orI,
        andI,
        xorI,
        norI,
        adduI,
        subuI,
        multuI,
        sltI,
        sltIu,
        mulOp    = 4'd12,                            // special2 group
        sebSehOp = 4'd13                             // special3 bshfl group
    } aluOpE;

    // control code seen by the datapath
    typedef enum logic [4:0] {
        ctlAdd   = 5'd0,
        ctlAddu,
        ctlSub,
        ctlMult,
        ctlMultu,
        ctlAnd,
        ctlOr,
        ctlNor,
        ctlXor,
        ctlSll,
        ctlSrl,
        ctlSllv,
        ctlSlt,
        ctlMovn,
        ctlMovz,
        ctlRotrv,
        ctlSra,
        ctlSrav,
        ctlSltu,
        ctlMul,
        ctlMadd,
        ctlMsub,
        ctlSebSeh,
        ctlMfhi,
        ctlMflo,
        ctlMthi,
        ctlMtlo  = 5'd26
    } aluCtrlE;

    // primary opcodes
    localparam logic [5:0] opSpecial  = 6'b000000;
    localparam logic [5:0] opSpecial2 = 6'b011100;
    localparam logic [5:0] opSpecial3 = 6'b011111;
    localparam logic [5:0] opAddi     = 6'b001000;
    localparam logic [5:0] opAddiu    = 6'b001001;
    localparam logic [5:0] opSlti     = 6'b001010;
    localparam logic [5:0] opSltiu    = 6'b001011;
    localparam logic [5:0] opAndi     = 6'b001100;
    localparam logic [5:0] opOri      = 6'b001101;
    localparam logic [5:0] opXori     = 6'b001110;

    // special function fields
    localparam logic [5:0] fnAdd   = 6'b100000;
    localparam logic [5:0] fnAddu  = 6'b100001;
    localparam logic [5:0] fnSub   = 6'b100010;
    localparam logic [5:0] fnMult  = 6'b011000;
    localparam logic [5:0] fnMultu = 6'b011001;
    localparam logic [5:0] fnAnd   = 6'b100100;
    localparam logic [5:0] fnOr    = 6'b100101;
    localparam logic [5:0] fnNor   = 6'b100111;
    localparam logic [5:0] fnXor   = 6'b100110;
    localparam logic [5:0] fnSll   = 6'b000000;
    localparam logic [5:0] fnSrl   = 6'b000010;
    localparam logic [5:0] fnSllv  = 6'b000100;
    localparam logic [5:0] fnSlt   = 6'b101010;
    localparam logic [5:0] fnMovn  = 6'b001011;
    localparam logic [5:0] fnMovz  = 6'b001010;
    localparam logic [5:0] fnRotrv = 6'b000110;
    localparam logic [5:0] fnSra   = 6'b000011;
    localparam logic [5:0] fnSrav  = 6'b000111;
    localparam logic [5:0] fnSltu  = 6'b101011;
    localparam logic [5:0] fnMfhi  = 6'b010000;
    localparam logic [5:0] fnMflo  = 6'b010010;
    localparam logic [5:0] fnMthi  = 6'b010001;
    localparam logic [5:0] fnMtlo  = 6'b010011;
    // special2 and special3 function fields
    localparam logic [5:0] fnMul   = 6'b000010;
    localparam logic [5:0] fnMadd  = 6'b000000;
    localparam logic [5:0] fnMsub  = 6'b000100;
    localparam logic [5:0] fnBshfl = 6'b100000;

    // bshfl sub-op in the sa field
    localparam logic [4:0] saSeb = 5'b10000;
    localparam logic [4:0] saSeh = 5'b11000;

endpackage
